// ==== verilog/lsu_consts.svh ====
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// lanes per warp
`define LSU_NUM_LANES 4

`define LSU_WID_BITS 2
`define LSU_RD_BITS 5

// outstanding load slots
`define LSU_TAGQ_SIZE 4
`define LSU_TAG_BITS 2

`endif

// ==== verilog/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    // bit 3 marks a store, bit 2 zero-extension, bits 1:0 log2 of the size
    typedef enum logic [3:0] {
        LB  = 4'b0000,
        LH  = 4'b0001,
        LW  = 4'b0010,
        LBU = 4'b0100,
        LHU = 4'b0101,
        SB  = 4'b1000,
        SH  = 4'b1001,
        SW  = 4'b1010
    } lsu_op_e;

endpackage

`default_nettype wire

// ==== verilog/lsu_req_stage.sv ====
`default_nettype none
`include "lsu_consts.svh"

module lsu_req_stage (
    input  wire                                  clk,
    input  wire                                  reset,
    input  wire                                  req_valid,
    input  wire lsu_pkg::lsu_op_e                req_op,
    input  wire [`LSU_WID_BITS-1:0]              req_wid,
    input  wire [31:0]                           req_pc,
    input  wire [`LSU_NUM_LANES-1:0]             req_tmask,
    input  wire [`LSU_NUM_LANES-1:0][31:0]       req_base_addr,
    input  wire [31:0]                           req_offset,
    input  wire [`LSU_RD_BITS-1:0]               req_rd,
    input  wire [`LSU_NUM_LANES-1:0][31:0]       req_store_data,
    input  wire                                  stall,
    output logic                                 req_ready,
    output logic                                 stg_valid,
    output lsu_pkg::lsu_op_e                     stg_op,
    output logic [`LSU_WID_BITS-1:0]             stg_wid,
    output logic [31:0]                          stg_pc,
    output logic [`LSU_NUM_LANES-1:0]            stg_tmask,
    output logic [`LSU_NUM_LANES-1:0][31:0]      stg_addr,
    output logic [`LSU_RD_BITS-1:0]              stg_rd,
    output logic [`LSU_NUM_LANES-1:0][31:0]      stg_data
);
    logic [`LSU_NUM_LANES-1:0][31:0] full_addr;

    // effective address per lane
    always_comb begin
        for (int i = 0; i < `LSU_NUM_LANES; i++) begin
            full_addr[i] = req_base_addr[i] + req_offset;
        end
    end

    assign req_ready = ~(stall && stg_valid);

    always_ff @(posedge clk) begin
        if (reset) begin
            stg_valid <= 1'b0;
        end else if (~stall) begin
            stg_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (~stall) begin
            stg_op    <= req_op;
            stg_wid   <= req_wid;
            stg_pc    <= req_pc;
            stg_tmask <= req_tmask;
            stg_addr  <= full_addr;
            stg_rd    <= req_rd;
            stg_data  <= req_store_data;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/lsu_mem_issue.sv ====
`default_nettype none
`include "lsu_consts.svh"

module lsu_mem_issue (
    input  wire                                  clk,
    input  wire                                  reset,
    input  wire                                  stg_valid,
    input  wire lsu_pkg::lsu_op_e                stg_op,
    input  wire [`LSU_WID_BITS-1:0]              stg_wid,
    input  wire [31:0]                           stg_pc,
    input  wire [`LSU_NUM_LANES-1:0]             stg_tmask,
    input  wire [`LSU_NUM_LANES-1:0][31:0]       stg_addr,
    input  wire [`LSU_NUM_LANES-1:0][31:0]       stg_data,
    input  wire [`LSU_NUM_LANES-1:0]             mem_req_ready,
    input  wire [`LSU_TAG_BITS-1:0]              tag_free,
    input  wire                                  tag_full,
    input  wire                                  st_commit_ready,
    output logic [`LSU_NUM_LANES-1:0]            mem_req_valid,
    output logic [`LSU_NUM_LANES-1:0][29:0]      mem_req_addr,
    output logic [`LSU_NUM_LANES-1:0][3:0]       mem_req_byteen,
    output logic [`LSU_NUM_LANES-1:0][31:0]      mem_req_data,
    output logic                                 mem_req_rw,
    output logic [`LSU_TAG_BITS-1:0]             mem_req_tag,
    output logic                                 alloc,
    output logic [`LSU_NUM_LANES-1:0]            alloc_tmask,
    output logic                                 stall,
    output logic                                 st_commit_valid,
    output logic [`LSU_WID_BITS-1:0]             st_commit_wid,
    output logic [31:0]                          st_commit_pc,
    output logic [`LSU_NUM_LANES-1:0]            st_commit_tmask
);
    logic                           is_store;
    logic                           dep_ready;
    logic                           all_sent;
    logic                           advance;
    logic                           is_start;
    logic [`LSU_NUM_LANES-1:0]      lane_fire;
    logic [`LSU_NUM_LANES-1:0]      sent_mask;
    logic [`LSU_NUM_LANES-1:0]      sent_mask_n;
    logic [`LSU_TAG_BITS-1:0]       tag_hold;

    // top op bit marks a store
    assign is_store = stg_op[3];

    // loads need a free slot before the first lane leaves
    assign dep_ready = is_store ? st_commit_ready : ~(tag_full && is_start);

    // every active lane either goes now or went earlier
    assign all_sent    = &(mem_req_ready | sent_mask | ~stg_tmask);
    assign advance     = stg_valid && dep_ready && all_sent;
    assign stall       = stg_valid && ~advance;
    assign lane_fire   = mem_req_valid & mem_req_ready;
    assign sent_mask_n = sent_mask | lane_fire;

    always_comb begin
        for (int i = 0; i < `LSU_NUM_LANES; i++) begin
            mem_req_valid[i] = stg_valid && dep_ready && stg_tmask[i] && ~sent_mask[i];
            mem_req_addr[i]  = stg_addr[i][31:2];
            mem_req_data[i]  = stg_data[i] << {stg_addr[i][1:0], 3'b000};
            case (stg_op)
                lsu_pkg::SB: mem_req_byteen[i] = 4'b0001 << stg_addr[i][1:0];
                lsu_pkg::SH: mem_req_byteen[i] = stg_addr[i][1] ? 4'b1100 : 4'b0011;
                default:     mem_req_byteen[i] = 4'b1111;
            endcase
        end
    end

    assign mem_req_rw = is_store;

    // later partial sends reuse the slot taken on the first one
    assign mem_req_tag = is_start ? tag_free : tag_hold;
    assign alloc       = ~is_store && is_start && (|lane_fire);
    assign alloc_tmask = stg_tmask;

    always_ff @(posedge clk) begin
        if (reset) begin
            sent_mask <= '0;
            is_start  <= 1'b1;
        end else if (advance) begin
            sent_mask <= '0;
            is_start  <= 1'b1;
        end else begin
            sent_mask <= sent_mask_n;
            is_start  <= (sent_mask_n == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            tag_hold <= tag_free;
        end
    end

    // store retires with its last lane
    assign st_commit_valid = stg_valid && is_store && all_sent;
    assign st_commit_wid   = stg_wid;
    assign st_commit_pc    = stg_pc;
    assign st_commit_tmask = stg_tmask;

endmodule

`default_nettype wire

// ==== verilog/lsu_tag_table.sv ====
`default_nettype none
`include "lsu_consts.svh"

module lsu_tag_table (
    input  wire                                  clk,
    input  wire                                  reset,
    input  wire                                  alloc,
    input  wire [`LSU_WID_BITS-1:0]              alloc_wid,
    input  wire [31:0]                           alloc_pc,
    input  wire [`LSU_RD_BITS-1:0]               alloc_rd,
    input  wire lsu_pkg::lsu_op_e                alloc_op,
    input  wire [`LSU_NUM_LANES-1:0]             alloc_tmask,
    input  wire [`LSU_NUM_LANES-1:0][1:0]        alloc_byte_offs,
    input  wire                                  rsp_fire,
    input  wire [`LSU_TAG_BITS-1:0]              rsp_tag,
    input  wire [`LSU_NUM_LANES-1:0]             rsp_tmask,
    output logic [`LSU_TAG_BITS-1:0]             tag_free,
    output logic                                 tag_full,
    output logic                                 tag_empty,
    output logic [`LSU_WID_BITS-1:0]             rd_wid,
    output logic [31:0]                          rd_pc,
    output logic [`LSU_RD_BITS-1:0]              rd_rd,
    output lsu_pkg::lsu_op_e                     rd_op,
    output logic [`LSU_NUM_LANES-1:0][1:0]       rd_byte_offs,
    output logic                                 rsp_last
);
    logic [`LSU_TAGQ_SIZE-1:0]          used;
    logic [`LSU_WID_BITS-1:0]           wid_mem  [`LSU_TAGQ_SIZE];
    logic [31:0]                        pc_mem   [`LSU_TAGQ_SIZE];
    logic [`LSU_RD_BITS-1:0]            rd_mem   [`LSU_TAGQ_SIZE];
    lsu_pkg::lsu_op_e                   op_mem   [`LSU_TAGQ_SIZE];
    logic [`LSU_NUM_LANES-1:0][1:0]     offs_mem [`LSU_TAGQ_SIZE];
    logic [`LSU_NUM_LANES-1:0]          rem_mask [`LSU_TAGQ_SIZE];
    logic [`LSU_NUM_LANES-1:0]          rem_mask_n;

    // lowest free entry wins
    always_comb begin
        tag_free = '0;
        for (int i = `LSU_TAGQ_SIZE - 1; i >= 0; i--) begin
            if (~used[i]) begin
                tag_free = `LSU_TAG_BITS'(i);
            end
        end
    end

    assign tag_full  = &used;
    assign tag_empty = ~|used;

    assign rd_wid       = wid_mem[rsp_tag];
    assign rd_pc        = pc_mem[rsp_tag];
    assign rd_rd        = rd_mem[rsp_tag];
    assign rd_op        = op_mem[rsp_tag];
    assign rd_byte_offs = offs_mem[rsp_tag];

    // lanes still owed after this response
    assign rem_mask_n = rem_mask[rsp_tag] & ~rsp_tmask;
    assign rsp_last   = (rem_mask_n == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            used <= '0;
        end else begin
            if (alloc) begin
                used[tag_free] <= 1'b1;
            end
            if (rsp_fire && rsp_last) begin
                used[rsp_tag] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            wid_mem[tag_free]  <= alloc_wid;
            pc_mem[tag_free]   <= alloc_pc;
            rd_mem[tag_free]   <= alloc_rd;
            op_mem[tag_free]   <= alloc_op;
            offs_mem[tag_free] <= alloc_byte_offs;
            rem_mask[tag_free] <= alloc_tmask;
        end
        if (rsp_fire) begin
            rem_mask[rsp_tag] <= rem_mask_n;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/lsu_load_format.sv ====
`default_nettype none
`include "lsu_consts.svh"

module lsu_load_format (
    input  wire                                  clk,
    input  wire                                  reset,
    input  wire                                  mem_rsp_valid,
    input  wire [`LSU_NUM_LANES-1:0]             mem_rsp_tmask,
    input  wire [`LSU_NUM_LANES-1:0][31:0]       mem_rsp_data,
    input  wire [`LSU_WID_BITS-1:0]              rd_wid,
    input  wire [31:0]                           rd_pc,
    input  wire [`LSU_RD_BITS-1:0]               rd_rd,
    input  wire lsu_pkg::lsu_op_e                rd_op,
    input  wire [`LSU_NUM_LANES-1:0][1:0]        rd_byte_offs,
    input  wire                                  rsp_last,
    input  wire                                  ld_commit_ready,
    output logic                                 mem_rsp_ready,
    output logic                                 rsp_fire,
    output logic                                 ld_commit_valid,
    output logic [`LSU_WID_BITS-1:0]             ld_commit_wid,
    output logic [31:0]                          ld_commit_pc,
    output logic [`LSU_NUM_LANES-1:0]            ld_commit_tmask,
    output logic [`LSU_RD_BITS-1:0]              ld_commit_rd,
    output logic [`LSU_NUM_LANES-1:0][31:0]      ld_commit_data,
    output logic                                 ld_commit_eop
);
    logic                               stall;
    logic [`LSU_NUM_LANES-1:0][31:0]    fmt_data;

    assign stall         = ld_commit_valid && ~ld_commit_ready;
    assign mem_rsp_ready = ~stall;
    assign rsp_fire      = mem_rsp_valid && mem_rsp_ready;

    // pick half, then byte, then extend
    always_comb begin
        logic [15:0] half_w;
        logic [7:0]  byte_w;
        for (int i = 0; i < `LSU_NUM_LANES; i++) begin
            half_w = rd_byte_offs[i][1] ? mem_rsp_data[i][31:16] : mem_rsp_data[i][15:0];
            byte_w = rd_byte_offs[i][0] ? half_w[15:8] : half_w[7:0];
            case (rd_op)
                lsu_pkg::LB:  fmt_data[i] = {{24{byte_w[7]}}, byte_w};
                lsu_pkg::LH:  fmt_data[i] = {{16{half_w[15]}}, half_w};
                lsu_pkg::LBU: fmt_data[i] = {24'b0, byte_w};
                lsu_pkg::LHU: fmt_data[i] = {16'b0, half_w};
                default:      fmt_data[i] = mem_rsp_data[i];
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ld_commit_valid <= 1'b0;
        end else if (~stall) begin
            ld_commit_valid <= mem_rsp_valid;
        end
    end

    // held while the commit side waits
    always_ff @(posedge clk) begin
        if (~stall) begin
            ld_commit_wid   <= rd_wid;
            ld_commit_pc    <= rd_pc;
            ld_commit_tmask <= mem_rsp_tmask;
            ld_commit_rd    <= rd_rd;
            ld_commit_data  <= fmt_data;
            ld_commit_eop   <= rsp_last;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/lsu_unit.sv ====
`default_nettype none
`include "lsu_consts.svh"

module lsu_unit (
    input  wire                                  clk,
    input  wire                                  reset,

    input  wire                                  req_valid,
    input  wire lsu_pkg::lsu_op_e                req_op,
    input  wire [`LSU_WID_BITS-1:0]              req_wid,
    input  wire [31:0]                           req_pc,
    input  wire [`LSU_NUM_LANES-1:0]             req_tmask,
    input  wire [`LSU_NUM_LANES-1:0][31:0]       req_base_addr,
    input  wire [31:0]                           req_offset,
    input  wire [`LSU_RD_BITS-1:0]               req_rd,
    input  wire [`LSU_NUM_LANES-1:0][31:0]       req_store_data,
    output logic                                 req_ready,

    output logic [`LSU_NUM_LANES-1:0]            mem_req_valid,
    output logic [`LSU_NUM_LANES-1:0][29:0]      mem_req_addr,
    output logic [`LSU_NUM_LANES-1:0][3:0]       mem_req_byteen,
    output logic [`LSU_NUM_LANES-1:0][31:0]      mem_req_data,
    output logic                                 mem_req_rw,
    output logic [`LSU_TAG_BITS-1:0]             mem_req_tag,
    input  wire [`LSU_NUM_LANES-1:0]             mem_req_ready,

    input  wire                                  mem_rsp_valid,
    input  wire [`LSU_NUM_LANES-1:0]             mem_rsp_tmask,
    input  wire [`LSU_NUM_LANES-1:0][31:0]       mem_rsp_data,
    input  wire [`LSU_TAG_BITS-1:0]              mem_rsp_tag,
    output logic                                 mem_rsp_ready,

    output logic                                 st_commit_valid,
    output logic [`LSU_WID_BITS-1:0]             st_commit_wid,
    output logic [31:0]                          st_commit_pc,
    output logic [`LSU_NUM_LANES-1:0]            st_commit_tmask,
    input  wire                                  st_commit_ready,

    output logic                                 ld_commit_valid,
    output logic [`LSU_WID_BITS-1:0]             ld_commit_wid,
    output logic [31:0]                          ld_commit_pc,
    output logic [`LSU_NUM_LANES-1:0]            ld_commit_tmask,
    output logic [`LSU_RD_BITS-1:0]              ld_commit_rd,
    output logic [`LSU_NUM_LANES-1:0][31:0]      ld_commit_data,
    output logic                                 ld_commit_eop,
    input  wire                                  ld_commit_ready
);
    // staged instruction
    logic                               stg_valid;
    lsu_pkg::lsu_op_e                   stg_op;
    logic [`LSU_WID_BITS-1:0]           stg_wid;
    logic [31:0]                        stg_pc;
    logic [`LSU_NUM_LANES-1:0]          stg_tmask;
    logic [`LSU_NUM_LANES-1:0][31:0]    stg_addr;
    logic [`LSU_RD_BITS-1:0]            stg_rd;
    logic [`LSU_NUM_LANES-1:0][31:0]    stg_data;
    logic                               stall;

    // slot allocation and lookup
    logic                               alloc;
    logic [`LSU_NUM_LANES-1:0]          alloc_tmask;
    logic [`LSU_NUM_LANES-1:0][1:0]     alloc_byte_offs;
    logic [`LSU_TAG_BITS-1:0]           tag_free;
    logic                               tag_full;
    logic                               tag_empty;
    logic [`LSU_WID_BITS-1:0]           rd_wid;
    logic [31:0]                        rd_pc;
    logic [`LSU_RD_BITS-1:0]            rd_rd;
    lsu_pkg::lsu_op_e                   rd_op;
    logic [`LSU_NUM_LANES-1:0][1:0]     rd_byte_offs;
    logic                               rsp_last;
    logic                               rsp_fire;

    for (genvar i = 0; i < `LSU_NUM_LANES; i++) begin : g_offs
        assign alloc_byte_offs[i] = stg_addr[i][1:0];
    end

    lsu_req_stage u_req_stage (.*);

    lsu_mem_issue u_mem_issue (.*);

    lsu_tag_table u_tag_table (
        .alloc_wid (stg_wid),
        .alloc_pc  (stg_pc),
        .alloc_rd  (stg_rd),
        .alloc_op  (stg_op),
        .rsp_tag   (mem_rsp_tag),
        .rsp_tmask (mem_rsp_tmask),
        .*
    );

    lsu_load_format u_load_format (.*);

endmodule

`default_nettype wire

// ==== sim/lsu_unit_props.sv ====
`default_nettype none
`include "lsu_consts.svh"

module lsu_unit_props (
    input wire                                  clk,
    input wire                                  reset,
    input wire                                  req_valid,
    input wire                                  req_ready,
    input wire lsu_pkg::lsu_op_e                req_op,
    input wire [`LSU_WID_BITS-1:0]              req_wid,
    input wire [31:0]                           req_pc,
    input wire [`LSU_NUM_LANES-1:0]             req_tmask,
    input wire [`LSU_NUM_LANES-1:0][31:0]       req_base_addr,
    input wire [31:0]                           req_offset,
    input wire [`LSU_NUM_LANES-1:0][31:0]       req_store_data,
    input wire [`LSU_NUM_LANES-1:0]             mem_req_valid,
    input wire [`LSU_NUM_LANES-1:0][29:0]       mem_req_addr,
    input wire [`LSU_NUM_LANES-1:0][3:0]        mem_req_byteen,
    input wire [`LSU_NUM_LANES-1:0][31:0]       mem_req_data,
    input wire                                  mem_req_rw,
    input wire [`LSU_NUM_LANES-1:0]             mem_req_ready,
    input wire                                  mem_rsp_ready,
    input wire                                  st_commit_valid,
    input wire [`LSU_WID_BITS-1:0]              st_commit_wid,
    input wire [31:0]                           st_commit_pc,
    input wire [`LSU_NUM_LANES-1:0]             st_commit_tmask,
    input wire                                  st_commit_ready,
    input wire                                  ld_commit_valid,
    input wire [`LSU_WID_BITS-1:0]              ld_commit_wid,
    input wire [31:0]                           ld_commit_pc,
    input wire [`LSU_RD_BITS-1:0]               ld_commit_rd,
    input wire [`LSU_NUM_LANES-1:0]             ld_commit_tmask,
    input wire [`LSU_NUM_LANES-1:0][31:0]       ld_commit_data,
    input wire                                  ld_commit_eop,
    input wire                                  ld_commit_ready
);
    logic [3:0]                         op_q;
    logic [`LSU_WID_BITS-1:0]           wid_q;
    logic [31:0]                        pc_q;
    logic [`LSU_NUM_LANES-1:0]          tmask_q;
    logic [`LSU_NUM_LANES-1:0][31:0]    ea_q;
    logic [`LSU_NUM_LANES-1:0][31:0]    sd_q;
    logic [`LSU_NUM_LANES-1:0]          fired;
    logic [`LSU_NUM_LANES-1:0]          fire_now;
    logic                               st_done;

    assign fire_now = mem_req_valid & mem_req_ready;

    // copy of the instruction that was last accepted
    always_ff @(posedge clk) begin
        if (reset) begin
            fired   <= '0;
            st_done <= 1'b0;
        end else if (req_valid && req_ready) begin
            op_q    <= req_op;
            wid_q   <= req_wid;
            pc_q    <= req_pc;
            tmask_q <= req_tmask;
            sd_q    <= req_store_data;
            for (int i = 0; i < `LSU_NUM_LANES; i++) begin
                ea_q[i] <= req_base_addr[i] + req_offset;
            end
            fired   <= '0;
            st_done <= 1'b0;
        end else begin
            fired <= fired | fire_now;
            if (st_commit_valid && st_commit_ready) begin
                st_done <= 1'b1;
            end
        end
    end

    for (genvar i = 0; i < `LSU_NUM_LANES; i++) begin : g_lane
        a_addr: assert property (@(posedge clk) disable iff (reset)
            mem_req_valid[i] |-> tmask_q[i] && !fired[i] && mem_req_addr[i] == ea_q[i][31:2])
            else $error("lane %0d request address or repeat", i);
        a_rw: assert property (@(posedge clk) disable iff (reset)
            mem_req_valid[i] |-> mem_req_rw == op_q[3])
            else $error("lane %0d rw", i);
        a_sb: assert property (@(posedge clk) disable iff (reset)
            mem_req_valid[i] && op_q == 4'b1000 |-> mem_req_byteen[i] == 4'(1 << ea_q[i][1:0]))
            else $error("lane %0d SB byte enable", i);
        a_sh: assert property (@(posedge clk) disable iff (reset)
            mem_req_valid[i] && op_q == 4'b1001
                |-> mem_req_byteen[i] == (ea_q[i][1] ? 4'b1100 : 4'b0011))
            else $error("lane %0d SH byte enable", i);
        a_full: assert property (@(posedge clk) disable iff (reset)
            mem_req_valid[i] && (op_q == 4'b1010 || !op_q[3]) |-> mem_req_byteen[i] == 4'hf)
            else $error("lane %0d full byte enable", i);
        a_sdata: assert property (@(posedge clk) disable iff (reset)
            mem_req_valid[i] && op_q[3]
                |-> mem_req_data[i] == (sd_q[i] << (8 * ea_q[i][1:0])))
            else $error("lane %0d store data shift", i);
    end

    a_st_commit: assert property (@(posedge clk) disable iff (reset)
        st_commit_valid && st_commit_ready |-> op_q[3] && !st_done && fire_now != '0
            && (fired | fire_now) == tmask_q && st_commit_wid == wid_q
            && st_commit_pc == pc_q && st_commit_tmask == tmask_q)
        else $error("store commit content or count");
    a_ld_hold: assert property (@(posedge clk) disable iff (reset)
        ld_commit_valid && !ld_commit_ready |=> ld_commit_valid && $stable(ld_commit_data)
            && $stable(ld_commit_tmask) && $stable(ld_commit_eop)
            && $stable(ld_commit_wid) && $stable(ld_commit_pc) && $stable(ld_commit_rd))
        else $error("load commit changed while stalled");
    a_rsp_bp: assert property (@(posedge clk) disable iff (reset)
        ld_commit_valid && !ld_commit_ready |-> !mem_rsp_ready)
        else $error("response accepted while commit stalled");
    a_reset: assert property (@(posedge clk)
        $past(reset) && !reset |-> mem_req_valid == '0 && !st_commit_valid && !ld_commit_valid)
        else $error("valid high right after reset");

endmodule

`default_nettype wire

// ==== sim/lsu_unit_tb.sv ====
`default_nettype none

module lsu_unit_tb;
    localparam int N_INSTR = 60;
    localparam int WORST = 40;
    localparam logic [31:0] MEM_KEY = 32'ha5c3_5a3c;

    typedef struct packed {
        logic [3:0]        tmask;
        logic              eop;
        logic [1:0]        wid;
        logic [31:0]       pc;
        logic [4:0]        rd;
        logic [3:0][31:0]  data;
    } commit_t;

    logic clk, reset;
    logic req_valid, req_ready, mem_req_rw, mem_rsp_valid, mem_rsp_ready;
    lsu_pkg::lsu_op_e req_op;
    logic [1:0] req_wid, mem_req_tag, mem_rsp_tag;
    logic [31:0] req_pc, req_offset;
    logic [4:0] req_rd;
    logic [3:0] req_tmask, mem_req_valid, mem_req_ready, mem_rsp_tmask;
    logic [3:0][31:0] req_base_addr, req_store_data, mem_req_data, mem_rsp_data;
    logic [3:0][29:0] mem_req_addr;
    logic [3:0][3:0] mem_req_byteen;
    logic st_commit_valid, st_commit_ready, ld_commit_valid, ld_commit_eop, ld_commit_ready;
    logic [1:0] st_commit_wid, ld_commit_wid;
    logic [31:0] st_commit_pc, ld_commit_pc;
    logic [3:0] st_commit_tmask, ld_commit_tmask;
    logic [4:0] ld_commit_rd;
    logic [3:0][31:0] ld_commit_data;

    logic [15:0] lfsr = 16'd51;
    lsu_pkg::lsu_op_e op_tab [8] = '{lsu_pkg::LB, lsu_pkg::LH, lsu_pkg::LW, lsu_pkg::LBU,
                                     lsu_pkg::LHU, lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW};
    // staged instruction as seen by the model
    lsu_pkg::lsu_op_e s_op;
    logic [3:0] s_tmask;
    logic [3:0][1:0] s_off;
    logic [1:0] s_wid;
    logic [31:0] s_pc;
    logic [4:0] s_rd;
    logic have_tag, accepted, rsp_busy;
    logic [3:0] pend_mask [4];
    logic [3:0] tag_rem [4];
    logic [3:0][31:0] pend_word [4];
    logic [3:0][31:0] pend_exp [4];
    logic [1:0] tag_wid [4];
    logic [31:0] tag_pc [4];
    logic [4:0] tag_rd [4];
    logic [3:0][31:0] rsp_exp;
    commit_t exp_q [$];
    int issued, done_cnt;

    lsu_unit u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] extend_load(lsu_pkg::lsu_op_e op, logic [31:0] w,
                                                logic [1:0] off);
        logic [31:0] b, h;
        b = w >> {off, 3'b000};
        h = w >> {off[1], 4'b0000};
        case (op)
            lsu_pkg::LB:  return {{24{b[7]}}, b[7:0]};
            lsu_pkg::LBU: return {24'b0, b[7:0]};
            lsu_pkg::LH:  return {{16{h[15]}}, h[15:0]};
            lsu_pkg::LHU: return {16'b0, h[15:0]};
            default:      return w;
        endcase
    endfunction

    task automatic report_fail(input string msg);
        $display("FAIL t=%0t %s", $time, msg);
        $display("Result: FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic observe();
        commit_t c;
        logic [3:0] fire;
        logic [1:0] t;
        accepted = req_valid && req_ready;
        if (mem_rsp_valid && mem_rsp_ready) begin
            t = mem_rsp_tag;
            c = '{tmask: mem_rsp_tmask, eop: (tag_rem[t] & ~mem_rsp_tmask) == 4'b0,
                  wid: tag_wid[t], pc: tag_pc[t], rd: tag_rd[t], data: rsp_exp};
            exp_q.push_back(c);
            tag_rem[t] &= ~mem_rsp_tmask;
            rsp_busy = 1'b0;
        end
        if (ld_commit_valid && ld_commit_ready) begin
            assert (exp_q.size() > 0) else report_fail("load commit with nothing pending");
            c = exp_q.pop_front();
            assert (ld_commit_tmask == c.tmask && ld_commit_eop == c.eop)
                else report_fail("load commit tmask or eop");
            assert (ld_commit_wid == c.wid && ld_commit_pc == c.pc && ld_commit_rd == c.rd)
                else report_fail("load commit wid, pc or rd");
            for (int i = 0; i < 4; i++) begin
                assert (!c.tmask[i] || ld_commit_data[i] == c.data[i])
                    else report_fail($sformatf("lane %0d load data %h, want %h",
                                               i, ld_commit_data[i], c.data[i]));
            end
            if (c.eop) done_cnt++;
        end
        if (st_commit_valid && st_commit_ready) done_cnt++;
        fire = mem_req_valid & mem_req_ready;
        if (fire != 4'b0 && !mem_req_rw) begin
            t = mem_req_tag;
            if (!have_tag) begin
                tag_rem[t] = s_tmask;
                tag_wid[t] = s_wid;
                tag_pc[t] = s_pc;
                tag_rd[t] = s_rd;
                have_tag = 1'b1;
            end
            for (int i = 0; i < 4; i++) begin
                if (fire[i]) begin
                    pend_word[t][i] = {2'b00, mem_req_addr[i]} ^ MEM_KEY;
                    pend_exp[t][i] = extend_load(s_op, pend_word[t][i], s_off[i]);
                    pend_mask[t][i] = 1'b1;
                end
            end
        end
        if (accepted) begin
            s_op = req_op;
            s_tmask = req_tmask;
            s_wid = req_wid;
            s_pc = req_pc;
            s_rd = req_rd;
            for (int i = 0; i < 4; i++) s_off[i] = 2'(req_base_addr[i] + req_offset);
            have_tag = 1'b0;
        end
    endtask

    task automatic drive();
        logic [31:0] r;
        logic [1:0] t;
        logic [3:0] part;
        r = next_bits(4);
        mem_req_ready = r[3:0];
        r = next_bits(2);
        st_commit_ready = |r[1:0];
        r = next_bits(2);
        ld_commit_ready = |r[1:0];
        if (!rsp_busy) begin
            mem_rsp_valid = 1'b0;
            r = next_bits(2);
            for (int k = 0; k < 4; k++) begin
                t = 2'(r[1:0] + k);
                if (!mem_rsp_valid && pend_mask[t] != 4'b0) begin
                    r = next_bits(4);
                    part = pend_mask[t] & r[3:0];
                    if (part == 4'b0) part = pend_mask[t];
                    mem_rsp_valid = 1'b1;
                    mem_rsp_tag = t;
                    mem_rsp_tmask = part;
                    for (int i = 0; i < 4; i++) begin
                        mem_rsp_data[i] = part[i] ? pend_word[t][i] : 32'b0;
                        rsp_exp[i] = pend_exp[t][i];
                    end
                    pend_mask[t] &= ~part;
                    rsp_busy = 1'b1;
                end
            end
        end
        if (!req_valid || accepted) begin
            req_valid = issued < N_INSTR;
            if (issued < N_INSTR) begin
                issued++;
                r = next_bits(3);
                req_op = op_tab[r[2:0]];
                r = next_bits(4);
                req_tmask = (r[3:0] == 4'b0) ? 4'b0001 : r[3:0];
                r = next_bits(2);
                req_wid = r[1:0];
                r = next_bits(32);
                req_pc = r;
                r = next_bits(5);
                req_rd = r[4:0];
                r = next_bits(32);
                req_offset = r;
                for (int i = 0; i < 4; i++) begin
                    r = next_bits(32);
                    req_base_addr[i] = r;
                    r = next_bits(32);
                    req_store_data[i] = r;
                end
            end
        end
    endtask

    initial begin
        #(N_INSTR * WORST * 20);
        $display("timeout: not all instructions committed in time");
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        reset = 1'b1;
        req_valid = 1'b0;
        req_op = lsu_pkg::LW;
        req_wid = '0;
        req_pc = '0;
        req_tmask = '0;
        req_base_addr = '0;
        req_offset = '0;
        req_rd = '0;
        req_store_data = '0;
        mem_req_ready = '0;
        mem_rsp_valid = 1'b0;
        mem_rsp_tmask = '0;
        mem_rsp_data = '0;
        mem_rsp_tag = '0;
        st_commit_ready = 1'b0;
        ld_commit_ready = 1'b0;
        for (int t = 0; t < 4; t++) begin
            pend_mask[t] = '0;
            tag_rem[t] = '0;
        end
        have_tag = 1'b0;
        accepted = 1'b0;
        rsp_busy = 1'b0;
        issued = 0;
        done_cnt = 0;
        repeat (3) @(posedge clk);
        #2 reset = 1'b0;
        drive();
        while (done_cnt < N_INSTR) begin
            @(negedge clk);
            observe();
            @(posedge clk);
            #2 drive();
        end
        // every slot should be back on the free list
        if (exp_q.size() == 0 && u_dut.tag_empty) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("load commits or tag entries still pending at the end");
            $display("Result: FAILED");
            $fatal(1, "pending state at end");
        end
    end

endmodule

bind lsu_unit lsu_unit_props u_props (.*);

`default_nettype wire

// ==== filelist.f ====
+incdir+verilog
verilog/lsu_pkg.sv
verilog/lsu_req_stage.sv
verilog/lsu_mem_issue.sv
verilog/lsu_tag_table.sv
verilog/lsu_load_format.sv
verilog/lsu_unit.sv
sim/lsu_unit_props.sv
sim/lsu_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
    --top-module lsu_unit_tb --Mdir obj_dir -o lsu_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/lsu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: PASSED" sim.log; then
    exit 0
fi
exit 1
